/* cpu_pkg.sv */
// ********************************************************************
// Shared exception definitions for the core.
// Exception codes are 3 bits, EX_NONE means no pending exception.
// Handler address is ivtbase joined with a VECT_WIDTH-bit offset.
// ********************************************************************

package cpu_pkg;

	// Exception kinds carried down the pipeline.
	typedef enum logic [2:0] {
		EX_NONE    = 3'd0,	// No exception.
		EX_BUSERR  = 3'd1,	// Bus error.
		EX_OVERFL  = 3'd2,	// Arithmetic overflow.
		EX_ADDRERR = 3'd3,	// Address error.
		EX_RESVDI  = 3'd4,	// Reserved instruction.
		EX_BREAK   = 3'd5,	// Break trap.
		EX_SYSCALL = 3'd6,	// System call trap.
		EX_HWINTR  = 3'd7	// Hardware interrupt.
	} ex_code_t;

	parameter int VECT_WIDTH = 10;	// Low part of a handler address.

	// Handler offsets inside the vector table, 0x20 apart.
	parameter logic [VECT_WIDTH-1:0] EXVECT_RESET   = 10'h000;
	parameter logic [VECT_WIDTH-1:0] EXVECT_BUSERR  = 10'h020;
	parameter logic [VECT_WIDTH-1:0] EXVECT_OVERFL  = 10'h040;
	parameter logic [VECT_WIDTH-1:0] EXVECT_ADDRERR = 10'h060;
	parameter logic [VECT_WIDTH-1:0] EXVECT_RESVDI  = 10'h080;
	parameter logic [VECT_WIDTH-1:0] EXVECT_BREAK   = 10'h0A0;
	parameter logic [VECT_WIDTH-1:0] EXVECT_SYSCALL = 10'h0C0;
	parameter logic [VECT_WIDTH-1:0] EXVECT_HWINTR  = 10'h0E0;

	parameter logic [31:0] RESET_VECTOR = 32'hBFC0_0000;	// PC after reset.

	// Map an exception kind to its offset in the vector table.
	function automatic logic [VECT_WIDTH-1:0] ex_vector(input ex_code_t code);
		case (code)
			EX_BUSERR:  return EXVECT_BUSERR;
			EX_OVERFL:  return EXVECT_OVERFL;
			EX_ADDRERR: return EXVECT_ADDRERR;
			EX_RESVDI:  return EXVECT_RESVDI;
			EX_BREAK:   return EXVECT_BREAK;
			EX_SYSCALL: return EXVECT_SYSCALL;
			EX_HWINTR:  return EXVECT_HWINTR;
			default:    return EXVECT_RESET;	// EX_NONE falls to reset.
		endcase
	endfunction

endpackage

/* coproc0_eiu.sv */
// ********************************************************************
// Exception and interrupt unit of coprocessor 0.
// Strobes are sampled only on non-stalled cycles; any stall freezes all.
// A fault in stage k reaches o_except_valid after 4-k non-stalled edges.
// Younger slots are dropped when an older stage faults.
// ********************************************************************

`timescale 1ns/100ps

module coproc0_eiu import cpu_pkg::*; #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic				clk,
	input  logic				nrst,
	input  logic				i_intr,			// External interrupt.
	input  logic				i_fetch_stall,
	input  logic				i_exec_stall,
	input  logic				i_mem_stall,
	input  logic				i_jump_valid,		// Branch in execute.
	input  logic [ADDR_WIDTH-VECT_WIDTH-1:0]	i_ivtbase,	// Vector table base.
	input  logic				i_ie,			// Interrupt enable.
	input  logic				i_bus_error_p0,
	input  logic				i_addr_error_p0,
	input  logic				i_decode_error_p1,
	input  logic				i_overfl_error_p2,
	input  logic				i_addr_error_p2,
	input  logic				i_syscall_trap_p2,
	input  logic				i_break_trap_p2,
	input  logic				i_bus_error_p3,
	input  logic				i_addr_error_p3,
	output logic				o_core_stall,
	output logic				o_except_start,
	output logic				o_except_dly_slt,
	output logic				o_except_valid,
	output logic [ADDR_WIDTH-1:0]		o_except_haddr,
	output ex_code_t			o_except_code,
	output logic				o_nullify_fetch,
	output logic				o_nullify_decode,
	output logic				o_nullify_execute,
	output logic				o_nullify_mem,
	output logic				o_nullify_wb
);

	ex_code_t	ex_p1;		// Code carried into decode.
	ex_code_t	ex_p2;		// Code carried into execute.
	ex_code_t	ex_p3;		// Code carried into memory.
	logic		dly_p2;		// Delay-slot flag in execute.
	logic		dly_p3;		// Delay-slot flag in memory.

	ex_code_t	ex_p1_nxt;
	ex_code_t	ex_p2_nxt;
	ex_code_t	ex_p3_nxt;
	ex_code_t	wb_code;	// Code resolved at writeback.

	logic		ex_state_p0;
	logic		ex_state_p1;
	logic		ex_state_p2;
	logic		ex_state_p3;
	logic		ex_state;

	assign o_core_stall = i_fetch_stall | i_exec_stall | i_mem_stall;	// Single stall.

	// Per-stage fault state, carried code or a fresh strobe.
	assign ex_state_p0 = i_bus_error_p0 | i_addr_error_p0;
	assign ex_state_p1 = (ex_p1 != EX_NONE) | i_decode_error_p1;
	assign ex_state_p2 = (ex_p2 != EX_NONE) | i_overfl_error_p2 | i_addr_error_p2 |
		i_syscall_trap_p2 | i_break_trap_p2;
	assign ex_state_p3 = (ex_p3 != EX_NONE) | i_bus_error_p3 | i_addr_error_p3;
	assign ex_state = ex_state_p0 | ex_state_p1 | ex_state_p2 | ex_state_p3;

	// Kill every stage younger than the oldest fault.
	assign o_nullify_fetch   = ex_state;
	assign o_nullify_decode  = ex_state;
	assign o_nullify_execute = ex_state_p1 | ex_state_p2 | ex_state_p3;
	assign o_nullify_mem     = ex_state_p2 | ex_state_p3;
	assign o_nullify_wb      = ex_state_p3;

	assign o_except_start   = ex_state_p3;	// Memory stage holds a fault.
	assign o_except_dly_slt = dly_p3;

	// Decode slot: fetch faults, else an interrupt if nothing is pending.
	always_comb
	begin
		if (ex_state_p1 | ex_state_p2 | ex_state_p3)
			ex_p1_nxt = EX_NONE;		// Nullified by an older fault.
		else if (i_bus_error_p0)
			ex_p1_nxt = EX_BUSERR;		// Bus error beats address error.
		else if (i_addr_error_p0)
			ex_p1_nxt = EX_ADDRERR;
		else if (i_intr & i_ie & ~o_except_valid)
			ex_p1_nxt = EX_HWINTR;		// Interrupt takes a free slot.
		else
			ex_p1_nxt = EX_NONE;
	end

	// Execute slot: reserved instruction replaces the carried code.
	always_comb
	begin
		if (ex_state_p2 | ex_state_p3)
			ex_p2_nxt = EX_NONE;
		else if (i_decode_error_p1)
			ex_p2_nxt = EX_RESVDI;
		else
			ex_p2_nxt = ex_p1;
	end

	// Memory slot: overflow, address, syscall, break.
	always_comb
	begin
		if (ex_state_p3)
			ex_p3_nxt = EX_NONE;
		else if (i_overfl_error_p2)
			ex_p3_nxt = EX_OVERFL;
		else if (i_addr_error_p2)
			ex_p3_nxt = EX_ADDRERR;
		else if (i_syscall_trap_p2)
			ex_p3_nxt = EX_SYSCALL;
		else if (i_break_trap_p2)
			ex_p3_nxt = EX_BREAK;
		else
			ex_p3_nxt = ex_p2;
	end

	// Writeback: own bus or address error wins over the carried code.
	always_comb
	begin
		if (i_bus_error_p3)
			wb_code = EX_BUSERR;
		else if (i_addr_error_p3)
			wb_code = EX_ADDRERR;
		else
			wb_code = ex_p3;
	end

	// Stage slot registers.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			ex_p1  <= EX_NONE;
			ex_p2  <= EX_NONE;
			ex_p3  <= EX_NONE;
			dly_p2 <= 1'b0;
			dly_p3 <= 1'b0;
		end
		else if (!o_core_stall)
		begin
			ex_p1  <= ex_p1_nxt;
			ex_p2  <= ex_p2_nxt;
			ex_p3  <= ex_p3_nxt;
			dly_p2 <= i_jump_valid;	// Next instruction sits in a delay slot.
			dly_p3 <= dly_p2;
		end
	end

	// Handler request, held while stalled.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_except_valid <= 1'b0;
			o_except_haddr <= '0;
			o_except_code  <= EX_NONE;
		end
		else if (!o_core_stall)
		begin
			o_except_valid <= (wb_code != EX_NONE);
			o_except_code  <= wb_code;
			if (wb_code != EX_NONE)
				o_except_haddr <= {i_ivtbase, ex_vector(wb_code)};	// Base and offset.
		end
	end

endmodule

/* coproc0_regs.sv */
// ********************************************************************
// Coprocessor 0 state kept between a fault and the handler return.
// All updates happen on non-stalled cycles only.
// Software write: sel 0 writes ie from bit 0, sel 1 writes ivtbase
// from the upper bits. An exception clears ie over a write or eret.
// ********************************************************************

`timescale 1ns/100ps

module coproc0_regs import cpu_pkg::*; #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic				clk,
	input  logic				nrst,
	input  logic				i_core_stall,
	input  logic				i_except_start,		// Fault in memory stage.
	input  logic				i_except_dly_slt,
	input  logic				i_except_valid,		// Handler request.
	input  ex_code_t			i_except_code,
	input  logic [ADDR_WIDTH-1:0]		i_pc_p3,		// PC of memory stage.
	input  logic				i_eret,
	input  logic				i_wr_en,
	input  logic				i_wr_sel,
	input  logic [ADDR_WIDTH-1:0]		i_wr_data,
	output logic [ADDR_WIDTH-VECT_WIDTH-1:0]	o_ivtbase,
	output logic				o_ie,
	output logic [ADDR_WIDTH-1:0]		o_epc,
	output ex_code_t			o_cause,
	output logic				o_dly
);

	logic	wr_status;	// Software write of ie.
	logic	wr_ivt;		// Software write of ivtbase.

	assign wr_status = i_wr_en & ~i_wr_sel;
	assign wr_ivt    = i_wr_en & i_wr_sel;

	// Vector table base.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_ivtbase <= '0;
		else if (!i_core_stall && wr_ivt)
			o_ivtbase <= i_wr_data[ADDR_WIDTH-1:VECT_WIDTH];
	end

	// Interrupt enable.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_ie <= 1'b0;
		else if (!i_core_stall)
		begin
			if (i_except_valid)
				o_ie <= 1'b0;		// Handler entry masks interrupts.
			else if (i_eret)
				o_ie <= 1'b1;		// Return re-enables them.
			else if (wr_status)
				o_ie <= i_wr_data[0];
		end
	end

	// Return address and delay-slot flag, taken at the fault.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			o_epc <= '0;
			o_dly <= 1'b0;
		end
		else if (!i_core_stall && i_except_start)
		begin
			o_epc <= i_pc_p3;
			o_dly <= i_except_dly_slt;
		end
	end

	// Cause code, taken with the handler request.
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_cause <= EX_NONE;
		else if (!i_core_stall && i_except_valid)
			o_cause <= i_except_code;
	end

endmodule

/* fetch_pc.sv */
// ********************************************************************
// Fetch program counter.
// Priority when not stalled: handler, then eret to epc, then PC+4.
// Resets to the low ADDR_WIDTH bits of RESET_VECTOR.
// ********************************************************************

`timescale 1ns/100ps

module fetch_pc import cpu_pkg::*; #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic			clk,
	input  logic			nrst,
	input  logic			i_core_stall,
	input  logic			i_except_valid,		// Jump to handler.
	input  logic [ADDR_WIDTH-1:0]	i_except_haddr,
	input  logic			i_eret,			// Return from handler.
	input  logic [ADDR_WIDTH-1:0]	i_epc,
	output logic [ADDR_WIDTH-1:0]	o_pc
);

	logic [ADDR_WIDTH-1:0]	pc_nxt;

	always_comb
	begin
		if (i_except_valid)
			pc_nxt = i_except_haddr;	// Handler wins over eret.
		else if (i_eret)
			pc_nxt = i_epc;
		else
			pc_nxt = o_pc + ADDR_WIDTH'(4);	// Sequential fetch.
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			o_pc <= RESET_VECTOR[ADDR_WIDTH-1:0];
		else if (!i_core_stall)
			o_pc <= pc_nxt;		// PC holds while stalled.
	end

endmodule

/* cpu_except_top.sv */
// ********************************************************************
// Exception path of the core: EIU, coprocessor 0 state and fetch PC.
// Stage strobes, stalls and the memory stage PC come from outside.
// ADDR_WIDTH must exceed VECT_WIDTH.
// ********************************************************************

`timescale 1ns/100ps

module cpu_except_top import cpu_pkg::*; #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic			clk,
	input  logic			nrst,
	input  logic			i_intr,
	input  logic			i_fetch_stall,
	input  logic			i_exec_stall,
	input  logic			i_mem_stall,
	input  logic			i_jump_valid,
	input  logic			i_bus_error_p0,
	input  logic			i_addr_error_p0,
	input  logic			i_decode_error_p1,
	input  logic			i_overfl_error_p2,
	input  logic			i_addr_error_p2,
	input  logic			i_syscall_trap_p2,
	input  logic			i_break_trap_p2,
	input  logic			i_bus_error_p3,
	input  logic			i_addr_error_p3,
	input  logic [ADDR_WIDTH-1:0]	i_pc_p3,
	input  logic			i_eret,
	input  logic			i_wr_en,
	input  logic			i_wr_sel,
	input  logic [ADDR_WIDTH-1:0]	i_wr_data,
	output logic [ADDR_WIDTH-1:0]	o_pc,
	output logic			o_except_valid,
	output logic [ADDR_WIDTH-1:0]	o_except_haddr,
	output ex_code_t		o_except_code,
	output logic [ADDR_WIDTH-1:0]	o_epc,
	output ex_code_t		o_cause,
	output logic			o_dly,
	output logic			o_ie,
	output logic			o_nullify_fetch,
	output logic			o_nullify_decode,
	output logic			o_nullify_execute,
	output logic			o_nullify_mem,
	output logic			o_nullify_wb
);

	logic				core_stall;	// OR of all stalls.
	logic				except_start;
	logic				except_dly_slt;
	logic [ADDR_WIDTH-VECT_WIDTH-1:0]	ivtbase;

	coproc0_eiu #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) coproc0_eiu_i (
		.clk(clk),
		.nrst(nrst),
		.i_intr(i_intr),
		.i_fetch_stall(i_fetch_stall),
		.i_exec_stall(i_exec_stall),
		.i_mem_stall(i_mem_stall),
		.i_jump_valid(i_jump_valid),
		.i_ivtbase(ivtbase),
		.i_ie(o_ie),
		.i_bus_error_p0(i_bus_error_p0),
		.i_addr_error_p0(i_addr_error_p0),
		.i_decode_error_p1(i_decode_error_p1),
		.i_overfl_error_p2(i_overfl_error_p2),
		.i_addr_error_p2(i_addr_error_p2),
		.i_syscall_trap_p2(i_syscall_trap_p2),
		.i_break_trap_p2(i_break_trap_p2),
		.i_bus_error_p3(i_bus_error_p3),
		.i_addr_error_p3(i_addr_error_p3),
		.o_core_stall(core_stall),
		.o_except_start(except_start),
		.o_except_dly_slt(except_dly_slt),
		.o_except_valid(o_except_valid),
		.o_except_haddr(o_except_haddr),
		.o_except_code(o_except_code),
		.o_nullify_fetch(o_nullify_fetch),
		.o_nullify_decode(o_nullify_decode),
		.o_nullify_execute(o_nullify_execute),
		.o_nullify_mem(o_nullify_mem),
		.o_nullify_wb(o_nullify_wb)
	);

	coproc0_regs #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) coproc0_regs_i (
		.clk(clk),
		.nrst(nrst),
		.i_core_stall(core_stall),
		.i_except_start(except_start),
		.i_except_dly_slt(except_dly_slt),
		.i_except_valid(o_except_valid),
		.i_except_code(o_except_code),
		.i_pc_p3(i_pc_p3),
		.i_eret(i_eret),
		.i_wr_en(i_wr_en),
		.i_wr_sel(i_wr_sel),
		.i_wr_data(i_wr_data),
		.o_ivtbase(ivtbase),
		.o_ie(o_ie),
		.o_epc(o_epc),
		.o_cause(o_cause),
		.o_dly(o_dly)
	);

	fetch_pc #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) fetch_pc_i (
		.clk(clk),
		.nrst(nrst),
		.i_core_stall(core_stall),
		.i_except_valid(o_except_valid),
		.i_except_haddr(o_except_haddr),
		.i_eret(i_eret),
		.i_epc(o_epc),
		.o_pc(o_pc)
	);

endmodule

/* tb_except_asserts.sv */
// **********************************************************************
// Assertions bound into every coproc0_eiu instance.
// Stall is sampled before the edge it freezes.
// **********************************************************************

`timescale 1ns/100ps

module tb_except_asserts #(
	parameter int ADDR_WIDTH = 32
) (
	input  logic			clk,
	input  logic			nrst,
	input  logic			i_stall,
	input  logic			i_valid,
	input  logic [ADDR_WIDTH-1:0]	i_haddr,
	input  logic [2:0]		i_code,
	input  logic			i_null_exe,
	input  logic			i_null_mem,
	input  logic			i_null_wb
);

	valid_in_reset: assert property (@(posedge clk) !nrst |-> !i_valid)
		else $error("handler request during reset");

	// A fault moves one stage older on each free edge.
	exe_to_mem: assert property (@(posedge clk) disable iff (!nrst)
		!i_stall && i_null_exe && !i_null_mem |=> i_null_mem)
		else $error("decode fault did not reach execute");

	mem_to_wb: assert property (@(posedge clk) disable iff (!nrst)
		!i_stall && i_null_mem && !i_null_wb |=> i_null_wb)
		else $error("execute fault did not reach memory");

	wb_to_valid: assert property (@(posedge clk) disable iff (!nrst)
		!i_stall && i_null_wb |=> i_valid)
		else $error("memory fault gave no handler request");

	hold_on_stall: assert property (@(posedge clk) disable iff (!nrst)
		i_stall |=> $stable(i_valid) && $stable(i_haddr) && $stable(i_code))
		else $error("handler outputs changed while stalled");

endmodule

bind coproc0_eiu tb_except_asserts #(
	.ADDR_WIDTH(ADDR_WIDTH)
) eiu_asserts_i (
	.clk(clk),
	.nrst(nrst),
	.i_stall(o_core_stall),
	.i_valid(o_except_valid),
	.i_haddr(o_except_haddr),
	.i_code(o_except_code),
	.i_null_exe(o_nullify_execute),
	.i_null_mem(o_nullify_mem),
	.i_null_wb(o_nullify_wb)
);

/* tb_except_checker.sv */
// **********************************************************************
// Checker for the exception path, samples the DUT on falling edges.
// Modes: 0 a fault is expected, 1 no handler request, 2 eret return.
// **********************************************************************

`timescale 1ns/100ps

module tb_except_checker import cpu_pkg::*; (
	input  logic		clk,
	input  logic		i_start,		// High in the strobe cycle.
	input  logic [1:0]	i_mode,
	input  int		i_test,
	input  ex_code_t	i_exp_code,
	input  logic [31:0]	i_exp_haddr,
	input  int		i_exp_lat,
	input  logic [4:0]	i_exp_null,
	input  logic [31:0]	i_exp_epc,
	input  logic		i_exp_dly,
	input  logic		i_stall,
	input  logic		i_valid,
	input  ex_code_t	i_code,
	input  logic [31:0]	i_haddr,
	input  logic [31:0]	i_pc,
	input  logic [31:0]	i_epc,
	input  ex_code_t	i_cause,
	input  logic		i_dly,
	input  logic		i_ie,
	input  logic [4:0]	i_null,
	output logic		o_done,
	output int		o_pass_cnt,
	output int		o_fail_cnt
);

	task automatic compare(input string name, input logic [31:0] exp,
		input logic [31:0] got, inout int errs);
		if (exp !== got)
		begin
			$display("MISMATCH test %0d %s exp %h got %h", i_test, name, exp, got);
			errs++;
		end
	endtask

	task automatic run_check();
		int	errs;
		int	edges;
		int	guard;
		logic	stalled;
		errs = 0;
		o_done = 1'b0;
		compare("nullify", {27'd0, i_exp_null}, {27'd0, i_null}, errs);	// Same cycle.
		if (i_mode == 2'd2)
		begin
			@(negedge clk);				// After the eret edge.
			compare("pc", i_exp_epc, i_pc, errs);
			compare("ie", 32'd1, {31'd0, i_ie}, errs);
		end
		else if (i_mode == 2'd1)
		begin
			repeat (8)
			begin
				@(negedge clk);
				if (i_valid)
				begin
					$display("test %0d: handler requested with nothing pending", i_test);
					errs++;
				end
			end
		end
		else
		begin
			edges = 0;
			guard = 0;
			stalled = i_stall;
			while (!i_valid && guard < 200)
			begin
				@(negedge clk);
				guard++;
				if (!stalled)
					edges++;		// Only non-stalled edges count.
				stalled = i_stall;
			end
			if (!i_valid)
			begin
				$display("test %0d: no handler request before timeout", i_test);
				errs++;
			end
			else
			begin
				compare("latency", i_exp_lat, edges, errs);
				compare("except_code", {29'd0, i_exp_code}, {29'd0, i_code}, errs);
				compare("except_haddr", i_exp_haddr, i_haddr, errs);
				guard = 0;
				while (i_stall && guard < 200)
				begin
					@(negedge clk);
					guard++;
				end
				if (i_stall)
				begin
					$display("test %0d: stall never released", i_test);
					errs++;
				end
				@(negedge clk);			// Handler edge has passed.
				compare("pc", i_exp_haddr, i_pc, errs);
				compare("ie", 32'd0, {31'd0, i_ie}, errs);
				compare("cause", {29'd0, i_exp_code}, {29'd0, i_cause}, errs);
				compare("epc", i_exp_epc, i_epc, errs);
				compare("dly", {31'd0, i_exp_dly}, {31'd0, i_dly}, errs);
			end
		end
		if (errs == 0)
		begin
			o_pass_cnt++;
			$display("test %0d ok", i_test);
		end
		else
		begin
			o_fail_cnt++;
			$display("test %0d failed with %0d errors", i_test, errs);
		end
		o_done = 1'b1;
	endtask

	initial
	begin
		o_done = 1'b0;
		o_pass_cnt = 0;
		o_fail_cnt = 0;
		forever
		begin
			@(negedge clk);
			if (i_start)
				run_check();
		end
	end

endmodule

/* tb_cpu_except.sv */
// **********************************************************************
// Testbench for the exception path, drives strobes, stalls and cp0 writes.
// Expected code, handler address and latency come from ref_except.
// Strobe bits: 0 bus_p0, 1 addr_p0, 2 decode_p1, 3 ovf_p2, 4 addr_p2,
// 5 syscall_p2, 6 break_p2, 7 bus_p3, 8 addr_p3.
// **********************************************************************

`timescale 1ns/100ps

module tb_cpu_except import cpu_pkg::*; ();

	logic		clk;
	logic		nrst;
	logic		intr;
	logic		fetch_stall;
	logic		exec_stall;
	logic		mem_stall;
	logic		jump_valid;
	logic [8:0]	strb;			// Stage error strobes.
	logic [31:0]	pc_p3;
	logic		eret;
	logic		wr_en;
	logic		wr_sel;
	logic [31:0]	wr_data;
	logic [31:0]	pc;
	logic		except_valid;
	logic [31:0]	except_haddr;
	ex_code_t	except_code;
	logic [31:0]	epc;
	ex_code_t	cause;
	logic		dly;
	logic		ie;
	logic [4:0]	nullify;		// wb, mem, execute, decode, fetch.

	logic		chk_start;
	logic [1:0]	chk_mode;		// 0 fault, 1 quiet, 2 eret.
	int		test_num;
	ex_code_t	exp_code;
	logic [31:0]	exp_haddr;
	int		exp_lat;
	logic [4:0]	exp_null;
	logic [31:0]	exp_epc;
	logic		exp_dly;
	logic		chk_done;
	int		pass_cnt;
	int		fail_cnt;

	int		seed = 87788;
	int		tn;			// Running test number.
	int		top_errs;
	logic		tb_ie;			// Model of the interrupt enable.
	logic [21:0]	tb_base;		// Model of the vector table base.

	cpu_except_top #(
		.ADDR_WIDTH(32)
	) cpu_except_top_i (
		.clk(clk),
		.nrst(nrst),
		.i_intr(intr),
		.i_fetch_stall(fetch_stall),
		.i_exec_stall(exec_stall),
		.i_mem_stall(mem_stall),
		.i_jump_valid(jump_valid),
		.i_bus_error_p0(strb[0]),
		.i_addr_error_p0(strb[1]),
		.i_decode_error_p1(strb[2]),
		.i_overfl_error_p2(strb[3]),
		.i_addr_error_p2(strb[4]),
		.i_syscall_trap_p2(strb[5]),
		.i_break_trap_p2(strb[6]),
		.i_bus_error_p3(strb[7]),
		.i_addr_error_p3(strb[8]),
		.i_pc_p3(pc_p3),
		.i_eret(eret),
		.i_wr_en(wr_en),
		.i_wr_sel(wr_sel),
		.i_wr_data(wr_data),
		.o_pc(pc),
		.o_except_valid(except_valid),
		.o_except_haddr(except_haddr),
		.o_except_code(except_code),
		.o_epc(epc),
		.o_cause(cause),
		.o_dly(dly),
		.o_ie(ie),
		.o_nullify_fetch(nullify[0]),
		.o_nullify_decode(nullify[1]),
		.o_nullify_execute(nullify[2]),
		.o_nullify_mem(nullify[3]),
		.o_nullify_wb(nullify[4])
	);

	tb_except_checker checker_i (
		.clk(clk),
		.i_start(chk_start),
		.i_mode(chk_mode),
		.i_test(test_num),
		.i_exp_code(exp_code),
		.i_exp_haddr(exp_haddr),
		.i_exp_lat(exp_lat),
		.i_exp_null(exp_null),
		.i_exp_epc(exp_epc),
		.i_exp_dly(exp_dly),
		.i_stall(fetch_stall | exec_stall | mem_stall),
		.i_valid(except_valid),
		.i_code(except_code),
		.i_haddr(except_haddr),
		.i_pc(pc),
		.i_epc(epc),
		.i_cause(cause),
		.i_dly(dly),
		.i_ie(ie),
		.i_null(nullify),
		.o_done(chk_done),
		.o_pass_cnt(pass_cnt),
		.o_fail_cnt(fail_cnt)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;		// 40 ns period.
	end

	// Expected result: the oldest faulting stage wins, then the in-stage order.
	function automatic void ref_except(input logic [8:0] s, input logic irq,
		input logic ie_now, input logic [21:0] base, output ex_code_t code,
		output logic [31:0] haddr, output int lat, output logic [4:0] nmask);
		int stage;
		stage = -1;
		code = EX_NONE;
		if (s[7] || s[8])
		begin
			code = s[7] ? EX_BUSERR : EX_ADDRERR;
			stage = 3;
		end
		else if (s[6:3] != 4'd0)
		begin
			if (s[3])
				code = EX_OVERFL;
			else if (s[4])
				code = EX_ADDRERR;
			else if (s[5])
				code = EX_SYSCALL;
			else
				code = EX_BREAK;
			stage = 2;
		end
		else if (s[2])
		begin
			code = EX_RESVDI;
			stage = 1;
		end
		else if (s[1:0] != 2'd0)
		begin
			code = s[0] ? EX_BUSERR : EX_ADDRERR;
			stage = 0;
		end
		else if (irq && ie_now)
			code = EX_HWINTR;		// Enters at decode, kills nothing yet.
		lat = (stage < 0) ? 4 : 4 - stage;
		nmask = {stage == 3, stage >= 2, stage >= 1, stage >= 0, stage >= 0};
		haddr = {base, 2'b00, code, 5'b00000};	// Offsets are 0x20 per code.
	endfunction

	// Wait for the checker, with random stalls if asked.
	task automatic wait_checker(input logic stall_en);
		logic [31:0]	r;
		int		guard;
		guard = 0;
		while (!chk_done && guard < 400)
		begin
			@(posedge clk);
			guard++;
			r = $random(seed);
			fetch_stall <= stall_en && (r[2:0] == 3'd0);
			exec_stall  <= stall_en && (r[5:3] == 3'd0);
			mem_stall   <= stall_en && (r[8:6] == 3'd0);
		end
		fetch_stall <= 1'b0;
		exec_stall  <= 1'b0;
		mem_stall   <= 1'b0;
		if (!chk_done)
		begin
			$display("test %0d: checker did not finish in time", tn);
			top_errs++;
		end
	endtask

	task automatic write_ie(input logic v);
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_sel  <= 1'b0;
		wr_data <= {31'd0, v};
		@(posedge clk);
		wr_en   <= 1'b0;
		tb_ie = v;
	endtask

	// One strobe set, optionally after a one-cycle pre strobe set.
	task automatic run_case(input logic [8:0] pre, input logic [8:0] s,
		input logic irq, input logic stall_en);
		logic [31:0]	r;
		logic [31:0]	pc_val;
		ex_code_t	code;
		logic [31:0]	haddr;
		int		lat;
		logic [4:0]	nm;
		@(posedge clk);
		r = $random(seed);
		wr_en      <= 1'b1;			// New random vector table base.
		wr_sel     <= 1'b1;
		wr_data    <= r;
		tb_base    = r[31:10];
		jump_valid <= r[0];
		exp_dly    <= r[0];
		r = $random(seed);
		pc_val     = {r[31:2], 2'b00};
		pc_p3      <= pc_val;
		@(posedge clk);
		wr_en <= 1'b0;
		repeat (2) @(posedge clk);		// Let the delay flag settle.
		if (pre != 9'd0)
		begin
			strb <= pre;
			@(posedge clk);
		end
		ref_except(s, irq, tb_ie, tb_base, code, haddr, lat, nm);
		tn++;
		test_num  <= tn;
		exp_code  <= code;
		exp_haddr <= haddr;
		exp_lat   <= lat;
		exp_null  <= nm;
		if (code != EX_NONE)
			exp_epc <= pc_val;		// epc only moves on a fault.
		chk_mode  <= (code == EX_NONE) ? 2'd1 : 2'd0;
		chk_start <= 1'b1;
		strb      <= s;
		intr      <= irq;
		@(posedge clk);
		strb      <= 9'd0;
		intr      <= 1'b0;
		chk_start <= 1'b0;
		if (code != EX_NONE)
			tb_ie = 1'b0;			// Handler entry masks interrupts.
		wait_checker(stall_en);
	endtask

	task automatic check_eret();
		@(posedge clk);
		tn++;
		test_num  <= tn;
		chk_mode  <= 2'd2;
		exp_null  <= 5'd0;
		eret      <= 1'b1;
		chk_start <= 1'b1;
		@(posedge clk);
		eret      <= 1'b0;
		chk_start <= 1'b0;
		tb_ie = 1'b1;
		wait_checker(1'b0);
	endtask

	initial
	begin
		logic [31:0]	r;
		nrst = 1'b0;
		intr = 1'b0;
		fetch_stall = 1'b0;
		exec_stall = 1'b0;
		mem_stall = 1'b0;
		jump_valid = 1'b0;
		strb = 9'd0;
		pc_p3 = 32'd0;
		eret = 1'b0;
		wr_en = 1'b0;
		wr_sel = 1'b0;
		wr_data = 32'd0;
		chk_start = 1'b0;
		chk_mode = 2'd0;
		test_num = 0;
		exp_code = EX_NONE;
		exp_haddr = 32'd0;
		exp_lat = 0;
		exp_null = 5'd0;
		exp_epc = 32'd0;
		exp_dly = 1'b0;
		tn = 0;
		top_errs = 0;
		tb_ie = 1'b0;
		tb_base = 22'd0;
		repeat (2) @(posedge clk);		// Reset for two cycles.
		nrst <= 1'b1;
		for (int i = 0; i < 9; i++)
			run_case(9'd0, 9'b1 << i, 1'b0, 1'b0);	// Single strobes.
		for (int i = 0; i < 9; i++)
			run_case(9'd0, 9'b1 << i, 1'b0, 1'b1);	// Same with stalls.
		run_case(9'd0, 9'b000000011, 1'b0, 1'b0);	// Bus over address at fetch.
		run_case(9'd0, 9'b001111000, 1'b0, 1'b0);	// Overflow first in execute.
		run_case(9'd0, 9'b001110000, 1'b0, 1'b0);
		run_case(9'd0, 9'b001100000, 1'b0, 1'b0);
		run_case(9'd0, 9'b000001001, 1'b0, 1'b0);	// Older stage wins.
		run_case(9'd0, 9'b010000100, 1'b0, 1'b0);
		run_case(9'd0, 9'b110000000, 1'b0, 1'b0);
		run_case(9'b000001000, 9'b010000000, 1'b0, 1'b0);	// Wb beats carried.
		check_eret();
		run_case(9'd0, 9'd0, 1'b1, 1'b0);		// Interrupt with ie set.
		run_case(9'd0, 9'd0, 1'b1, 1'b0);		// Now ie is clear.
		check_eret();
		run_case(9'd0, 9'd0, 1'b1, 1'b1);
		write_ie(1'b1);
		run_case(9'd0, 9'd0, 1'b1, 1'b1);
		for (int i = 0; i < 12; i++)
		begin
			r = $random(seed);
			run_case(9'd0, r[17:9], 1'b0, r[0]);	// Random combinations.
		end
		check_eret();
		repeat (2) @(posedge clk);
		$display("Tests: %0d passed, %0d failed, %0d other errors",
			pass_cnt, fail_cnt, top_errs);
		if (fail_cnt == 0 && top_errs == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		#2ms;
		$display("Run exceeded its time limit");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* files.f */
cpu_pkg.sv
coproc0_eiu.sv
coproc0_regs.sv
fetch_pc.sv
cpu_except_top.sv
tb_except_asserts.sv
tb_except_checker.sv
tb_cpu_except.sv

/* Makefile */
# Verilator simulation of the exception path testbench.

VERILATOR ?= verilator
TOP       ?= tb_cpu_except
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
